// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = mips_system_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/data_mem.sv ====
`include "mips_config.svh"

module data_mem
    import mips_pkg::*;
(
    input  logic  clk,
    input  word_t data_address,
    input  logic  data_write,
    input  word_t data_writedata,
    output word_t data_readdata,
    input  word_t probe_address,
    output word_t probe_readdata
);

    localparam int ADDR_BITS = $clog2(`MIPS_DMEM_WORDS);

    word_t mem [0:`MIPS_DMEM_WORDS-1];

    word_t data_offset;
    word_t probe_offset;
    logic [ADDR_BITS-1:0] data_index;
    logic [ADDR_BITS-1:0] probe_index;

    // byte addresses become word indexes above the base.
    assign data_offset  = data_address - `MIPS_DMEM_BASE;
    assign probe_offset = probe_address - `MIPS_DMEM_BASE;
    assign data_index   = data_offset[ADDR_BITS+1:2];
    assign probe_index  = probe_offset[ADDR_BITS+1:2];

    assign data_readdata = mem[data_index];

    // the probe port sees the memory as the core left it.
    assign probe_readdata = mem[probe_index];

    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[data_index] <= data_writedata;
        end
    end

endmodule

// ==== hw/instr_mem.sv ====
`include "mips_config.svh"

module instr_mem
    import mips_pkg::*;
(
    input  logic  clk,
    input  word_t instr_address,
    output word_t instr_readdata,
    input  logic  prog_write,
    input  word_t prog_address,
    input  word_t prog_writedata
);

    localparam int ADDR_BITS = $clog2(`MIPS_IMEM_WORDS);

    word_t mem [0:`MIPS_IMEM_WORDS-1];

    word_t fetch_offset;
    word_t load_offset;

    // offsets from the reset vector, upper bits dropped.
    assign fetch_offset = instr_address - `MIPS_RESET_VECTOR;
    assign load_offset  = prog_address - `MIPS_RESET_VECTOR;

    assign instr_readdata = mem[fetch_offset[ADDR_BITS+1:2]];

    always_ff @(posedge clk) begin
        if (prog_write) begin
            mem[load_offset[ADDR_BITS+1:2]] <= prog_writedata;
        end
    end

endmodule

// ==== hw/mips_alu.sv ====
module mips_alu
    import mips_pkg::*;
(
    input  alu_op_t    op,
    input  word_t      operand_a,
    input  word_t      operand_b,
    input  logic [4:0] shift_amount,
    output word_t      result,
    output logic       equal
);

    logic signed_less;
    logic unsigned_less;

    assign signed_less   = $signed(operand_a) < $signed(operand_b);
    assign unsigned_less = operand_a < operand_b;

    // shifts act on operand b, which carries rt.
    always_comb begin
        case (op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_AND:  result = operand_a & operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_SLT:  result = {31'b0, signed_less};
            ALU_SLTU: result = {31'b0, unsigned_less};
            ALU_SLL:  result = operand_b << shift_amount;
            ALU_SRL:  result = operand_b >> shift_amount;
            ALU_LUI:  result = {operand_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // compare for beq and bne.
    assign equal = (operand_a == operand_b);

endmodule

// ==== hw/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// address of the first instruction after reset.
`define MIPS_RESET_VECTOR 32'hBFC00000

// instruction memory depth in words.
`define MIPS_IMEM_WORDS 256

// data memory starts at this byte address.
`define MIPS_DMEM_BASE 32'h00000400

`define MIPS_DMEM_WORDS 256

`endif

// ==== hw/mips_cpu_harvard.sv ====
`include "mips_config.svh"

module mips_cpu_harvard
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  clk_enable,
    output logic  active,
    output word_t register_v0,
    output word_t instr_address,
    input  word_t instr_readdata,
    output word_t data_address,
    output logic  data_write,
    output logic  data_read,
    output word_t data_writedata,
    input  word_t data_readdata
);

    word_t      pc;
    word_t      npc;
    logic       halt_pending;
    logic       retire;
    opcode_t    opcode;
    funct_t     funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [15:0] imm;
    word_t      imm_ext;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       zero_ext;
    logic       reg_write;
    logic       dest_rt;
    logic       is_load;
    logic       is_store;
    logic       is_jr;
    logic       take_branch;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    logic       alu_equal;
    word_t      branch_target;

    // ====================
    // decode
    // ====================

    assign opcode = opcode_t'(instr_readdata[31:26]);
    assign funct  = funct_t'(instr_readdata[5:0]);
    assign rs     = instr_readdata[25:21];
    assign rt     = instr_readdata[20:16];
    assign rd     = instr_readdata[15:11];
    assign shamt  = instr_readdata[10:6];
    assign imm    = instr_readdata[15:0];

    assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        reg_write = 1'b0;
        dest_rt   = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                use_imm   = 1'b0;
                dest_rt   = 1'b0;
                reg_write = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLTU:  alu_op = ALU_SLTU;
                    F_SLL:   alu_op = ALU_SLL;
                    F_SRL:   alu_op = ALU_SRL;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: reg_write = 1'b1;
            OP_ANDI: begin
                alu_op    = ALU_AND;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_OR;
                zero_ext  = 1'b1;
                reg_write = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                reg_write = 1'b1;
            end
            OP_LW:   reg_write = 1'b1;
            // branches compare rs with rt in the ALU.
            OP_BEQ, OP_BNE: use_imm = 1'b0;
            default: ;
        endcase
    end

    assign is_load  = (opcode == OP_LW);
    assign is_store = (opcode == OP_SW);
    assign is_jr    = (opcode == OP_SPECIAL) && (funct == F_JR);

    // ====================
    // datapath
    // ====================

    mips_regfile u_regfile (
        .clk          (clk),
        .arst_n       (arst_n),
        .read_a_index (rs),
        .read_b_index (rt),
        .read_a_data  (rs_data),
        .read_b_data  (rt_data),
        .write_enable (reg_write && retire),
        .write_index  (dest_rt ? rt : rd),
        .write_data   (is_load ? data_readdata : alu_result),
        .v0_data      (register_v0)
    );

    mips_alu u_alu (
        .op           (alu_op),
        .operand_a    (rs_data),
        .operand_b    (use_imm ? imm_ext : rt_data),
        .shift_amount (shamt),
        .result       (alu_result),
        .equal        (alu_equal)
    );

    assign take_branch = ((opcode == OP_BEQ) && alu_equal) ||
                         ((opcode == OP_BNE) && !alu_equal);

    // offset counts from the delay slot address.
    assign branch_target = pc + 32'd4 + {imm_ext[29:0], 2'b00};

    assign instr_address  = pc;
    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_read      = is_load && active;
    assign data_write     = is_store && active;

    // ====================
    // sequencing
    // ====================

    assign retire = clk_enable && active;

    // npc holds the delay slot, so a redirect lands one retirement later.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= `MIPS_RESET_VECTOR;
            npc          <= `MIPS_RESET_VECTOR + 32'd4;
            halt_pending <= 1'b0;
            active       <= 1'b1;
        end else if (retire) begin
            pc           <= npc;
            halt_pending <= is_jr && (rs_data == '0);
            if (is_jr) begin
                npc <= rs_data;
            end else if (take_branch) begin
                npc <= branch_target;
            end else begin
                npc <= npc + 32'd4;
            end
            // the delay slot of a jr to zero has just retired.
            if (halt_pending) begin
                active <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;

    // primary opcodes, bits 31 to 26 of the instruction.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_t;

    // function codes of the SPECIAL opcode, bits 5 to 0.
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

endpackage

// ==== hw/mips_regfile.sv ====
module mips_regfile
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [4:0] read_a_index,
    input  logic [4:0] read_b_index,
    output word_t      read_a_data,
    output word_t      read_b_data,
    input  logic       write_enable,
    input  logic [4:0] write_index,
    input  word_t      write_data,
    output word_t      v0_data
);

    // register zero is not stored.
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_index != 5'd0)) begin
            regs[write_index] <= write_data;
        end
    end

    assign read_a_data = (read_a_index == 5'd0) ? '0 : regs[read_a_index];
    assign read_b_data = (read_b_index == 5'd0) ? '0 : regs[read_b_index];

    // v0 is register 2 and carries the program result.
    assign v0_data = regs[2];

endmodule

// ==== hw/mips_system.sv ====
module mips_system
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  clk_enable,
    output logic  active,
    output word_t register_v0,
    input  logic  prog_write,
    input  word_t prog_address,
    input  word_t prog_writedata,
    input  word_t probe_address,
    output word_t probe_readdata
);

    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_write;
    word_t data_writedata;
    word_t data_readdata;

    // ====================
    // core
    // ====================

    // data_mem reads combinationally, so the read strobe is left open.
    mips_cpu_harvard u_cpu (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // ====================
    // memories
    // ====================

    instr_mem u_instr_mem (
        .clk            (clk),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .prog_write     (prog_write),
        .prog_address   (prog_address),
        .prog_writedata (prog_writedata)
    );

    // a stalled cycle must not store.
    data_mem u_data_mem (
        .clk            (clk),
        .data_address   (data_address),
        .data_write     (data_write & clk_enable),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .probe_address  (probe_address),
        .probe_readdata (probe_readdata)
    );

endmodule

// ==== verification/clock_gen.sv ====
module clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 5;

    // free-running clock with a period of ten time units.
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// ==== verification/mips_system_tb.sv ====
`include "mips_config.svh"

module mips_system_tb
    import mips_pkg::*;
();

    localparam int VEC_WORDS    = 512;
    localparam int EXTRA_CYCLES = 20;

    logic  clk;
    logic  arst_n;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    logic  prog_write;
    word_t prog_address;
    word_t prog_writedata;
    word_t probe_address;
    word_t probe_readdata;

    word_t       vec [0:VEC_WORDS-1];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    clock_gen u_clock_gen (
        .clk (clk)
    );

    mips_system u_mips_system (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .prog_write     (prog_write),
        .prog_address   (prog_address),
        .prog_writedata (prog_writedata),
        .probe_address  (probe_address),
        .probe_readdata (probe_readdata)
    );

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a record holds number, length, program, v0, pair count and the pairs.
    function automatic int next_record(input int base);
        int len;
        int pairs;
        len   = vec[base + 1];
        pairs = vec[base + 3 + len];
        return base + 4 + len + 2 * pairs;
    endfunction

    function automatic logic record_valid(input int base);
        return (base < VEC_WORDS) && !$isunknown(vec[base]) && (vec[base] != 32'hFFFFFFFF);
    endfunction

    // each test is allowed four cycles per program word plus reset and load margin.
    function automatic int timeout_limit();
        int base;
        int limit;
        int len;
        base  = 0;
        limit = 0;
        while (record_valid(base)) begin
            len = vec[base + 1];
            if (vec[base][16]) begin
                limit += 2 * (len * 4 + 8);
            end else begin
                limit += len * 4 + 8;
            end
            base = next_record(base);
        end
        return limit;
    endfunction

    task automatic reset_and_load(input int at, input int len);
        int cycles;
        cycles     = (len > 4) ? len : 4;
        arst_n     = 1'b0;
        clk_enable = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #2;
            if (i < len) begin
                prog_write     = 1'b1;
                prog_address   = `MIPS_RESET_VECTOR + 32'(4 * i);
                prog_writedata = vec[at + i];
            end else begin
                prog_write = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        prog_write = 1'b0;
        arst_n     = 1'b1;
        clk_enable = 1'b1;
    endtask

    task automatic run_program(input logic stall);
        while (active) begin
            if (stall) begin
                rng_state  = next_random(rng_state);
                clk_enable = rng_state[0];
            end
            @(posedge clk);
            #2;
        end
        clk_enable = 1'b1;
    endtask

    task automatic check_results(input logic [15:0] number, input int at);
        int    count;
        word_t address;
        word_t expected;
        count = vec[at + 1];
        if (register_v0 !== vec[at]) begin
            $display("FAIL test %0d register_v0 got %h expected %h",
                     number, register_v0, vec[at]);
            test_errors++;
        end
        for (int i = 0; i < count; i++) begin
            address       = vec[at + 2 + 2 * i];
            expected      = vec[at + 3 + 2 * i];
            probe_address = address;
            #1;
            if (probe_readdata !== expected) begin
                $display("FAIL test %0d probe_readdata at %h got %h expected %h",
                         number, address, probe_readdata, expected);
                test_errors++;
            end
        end
    endtask

    // a second reset must bring the core back with cleared registers.
    task automatic check_restart(input logic [15:0] number);
        arst_n     = 1'b0;
        clk_enable = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        if (active !== 1'b1) begin
            $display("test %0d: the core did not become active after a new reset", number);
            test_errors++;
        end
        if (register_v0 !== 32'h0) begin
            $display("FAIL test %0d register_v0 got %h expected %h",
                     number, register_v0, 32'h0);
            test_errors++;
        end
    endtask

    // ====================
    // timeout
    // ====================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core never went inactive", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ====================
    // test sequence
    // ====================

    initial begin
        int          base;
        int          len;
        logic [15:0] mode;
        logic [15:0] number;
        arst_n         = 1'b0;
        clk_enable     = 1'b0;
        prog_write     = 1'b0;
        prog_address   = '0;
        prog_writedata = '0;
        probe_address  = `MIPS_DMEM_BASE;
        rng_state      = 32'hf1720c20;
        error_count    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        // unread words look like the end marker.
        for (int i = 0; i < VEC_WORDS; i++) begin
            vec[i] = '1;
        end
        $readmemh("verification/mips_vectors.hex", vec);
        if (vec[0] == 32'hFFFFFFFF) begin
            $display("the vectors file could not be read");
            error_count++;
        end
        cycle_limit = timeout_limit();
        base        = 0;
        while (record_valid(base)) begin
            mode        = vec[base][31:16];
            number      = vec[base][15:0];
            len         = vec[base + 1];
            test_errors = 0;
            reset_and_load(base + 2, len);
            run_program(mode[0]);
            check_results(number, base + 2 + len);
            // once halted, further cycles must not disturb anything.
            if (mode[1]) begin
                repeat (EXTRA_CYCLES) @(posedge clk);
                #2;
                if (active !== 1'b0) begin
                    $display("test %0d: the core became active again without a reset",
                             number);
                    test_errors++;
                end
                check_results(number, base + 2 + len);
                check_restart(number);
            end
            tests_run++;
            error_count += test_errors;
            if (test_errors == 0) begin
                $display("PASS test %0d", number);
            end else begin
                $display("FAIL test %0d with %0d mismatches", number, test_errors);
                tests_failed++;
            end
            base = next_record(base);
        end
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_run > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/mips_vectors.hex ====
// record: test number (upper half is the mode, bit 16 random stalls, bit 17 post-halt checks),
// program length, program words, expected v0, data pair count, then address and value pairs.
// test 1: addiu chain, sign extension and wrap
00000001 00000008
2402FFFF 2442FFFB 24037FFF 24420010 24428000 00431021 00000008 00000000
00000009 00000000
// test 2: logic, shifts and signed against unsigned compare
00000002 00000013
3C048000 348400F0 24050FF0 00853024 00853825 00E64026 3109FF00 00045702
000A5900 0085602A 0085682B 00A47023 012B1021 000C6400 004C1025 004D1025
004E1023 00000008 00000000
80010080 00000000
// test 3: stores, loads and arithmetic on loaded values
00000003 00000011
24040400 24051234 3C06DEAD 34C6BEEF 2407FFFE AC850000 AC860004 AC870008
AC8603FC 8C880000 8C890004 8C8A0008 01091021 004A1023 AC82000C 00000008
00000000
DEADD125 00000005
00000400 00001234 00000404 DEADBEEF 00000408 FFFFFFFE 0000040C DEADD125
000007FC DEADBEEF
// test 4: beq and bne loop with delay slots
00000004 00000011
24020000 24040005 24420001 2484FFFF 1480FFFD 24420010 10000002 24420100
24421000 10400004 24422000 14420002 00000008 24424000 24427000 00000008
00000000
00006155 00000000
// test 5: test 3 again under random stalls
00010005 00000011
24040400 24051234 3C06DEAD 34C6BEEF 2407FFFE AC850000 AC860004 AC870008
AC8603FC 8C880000 8C890004 8C8A0008 01091021 004A1023 AC82000C 00000008
00000000
DEADD125 00000005
00000400 00001234 00000404 DEADBEEF 00000408 FFFFFFFE 0000040C DEADD125
000007FC DEADBEEF
// test 6: halt, idle cycles, then a new reset
00020006 00000006
24040400 24020055 00000008 AC820010 AC800010 24020000
00000055 00000001
00000410 00000055
FFFFFFFF

// ==== verilog.f ====
+incdir+hw
hw/mips_pkg.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_cpu_harvard.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/mips_system.sv
verification/clock_gen.sv
verification/mips_system_tb.sv
